//--- common/coef_if.sv
interface coef_if;
  import lrelu_pkg::*;

  logic valid;
  logic lrelu;
  logic [GROUPS-1:0][UNITS-1:0][WORD_WIDTH_IN-1:0] data;  // lanes, delayed with the read

  // per group coefficients for this beat
  logic [GROUPS-1:0][COEF_WIDTH-1:0] scale;
  logic [GROUPS-1:0][COEF_WIDTH-1:0] bias;
  logic [GROUPS-1:0][COEF_WIDTH-1:0] d;

  modport source (
    output valid, lrelu, data, scale, bias, d
  );

  modport sink (
    input valid, lrelu, data, scale, bias, d
  );

endinterface

//--- common/lrelu_pkg.sv
package lrelu_pkg;

  // array shape
  localparam int GROUPS         = 2;
  localparam int UNITS          = 4;

  localparam int WORD_WIDTH_IN  = 32;  // accumulator word
  localparam int WORD_WIDTH_OUT = 8;
  localparam int COEF_WIDTH     = 16;  // scale, bias and d
  localparam int CFG_WIDTH      = 32;  // one config word per group
  localparam int PROD_WIDTH     = 48;

  localparam int KERNEL_DEPTH   = 4;
  localparam int ADDR_WIDTH     = $clog2(KERNEL_DEPTH);

  localparam int FRAC_SCALE     = 8;
  localparam int ALPHA_FRAC     = 8;
  localparam logic signed [COEF_WIDTH-1:0] LRELU_ALPHA = 16'sd26;  // ~0.1
  localparam int OUT_SHIFT      = 4;
  localparam int PIPE_LATENCY   = 4;   // enabled cycles, s_valid to m_valid

  localparam int SAT_MAX        = 2**(WORD_WIDTH_OUT-1) - 1;
  localparam int SAT_MIN        = -(2**(WORD_WIDTH_OUT-1));

  // d word, upper half ignored
  typedef struct packed {
    logic [CFG_WIDTH-COEF_WIDTH-1:0] pad;
    logic signed [COEF_WIDTH-1:0]    d;
  } cfg_d_t;

  typedef struct packed {
    logic signed [COEF_WIDTH-1:0] bias;
    logic signed [COEF_WIDTH-1:0] scale;
  } cfg_coef_t;

  // one config word, two readings
  typedef union packed {
    cfg_d_t    d_view;
    cfg_coef_t coef_view;
  } cfg_word_u;

  typedef enum logic {LOAD_D, LOAD_COEF} cfg_sel_e;

endpackage

//--- config/coef_store.sv
module coef_store (
  input  logic clk,
  input  logic reset,
  input  logic clken,
  input  lrelu_pkg::cfg_word_u [lrelu_pkg::GROUPS-1:0] config_data,
  input  logic d_we,
  input  logic coef_we,
  input  logic [lrelu_pkg::ADDR_WIDTH-1:0] coef_waddr,
  input  logic config_restart,
  input  logic s_valid,
  input  logic s_lrelu,
  input  logic [lrelu_pkg::GROUPS-1:0][lrelu_pkg::UNITS-1:0][lrelu_pkg::WORD_WIDTH_IN-1:0] s_data,
  coef_if.source coef
);
  import lrelu_pkg::*;

  logic [COEF_WIDTH-1:0] scale_mem [GROUPS][KERNEL_DEPTH];
  logic [COEF_WIDTH-1:0] bias_mem  [GROUPS][KERNEL_DEPTH];
  logic [COEF_WIDTH-1:0] d_reg     [GROUPS];
  logic [ADDR_WIDTH-1:0] rd_ptr;

  // config write port
  always_ff @(posedge clk) begin
    if (clken) begin
      for (int g = 0; g < GROUPS; g++) begin
        if (d_we)
          d_reg[g] <= config_data[g].d_view.d;
        if (coef_we) begin
          scale_mem[g][coef_waddr] <= config_data[g].coef_view.scale;
          bias_mem[g][coef_waddr]  <= config_data[g].coef_view.bias;
        end
      end
    end
  end

  // cyclic read pointer, one step per accepted beat
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
    end else if (clken) begin
      if (config_restart)
        rd_ptr <= '0;
      else if (s_valid)
        rd_ptr <= (rd_ptr == ADDR_WIDTH'(KERNEL_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset)
      coef.valid <= 1'b0;
    else if (clken)
      coef.valid <= s_valid;
  end

  // registered read, beat travels alongside
  always_ff @(posedge clk) begin
    if (clken) begin
      coef.lrelu <= s_lrelu;
      coef.data  <= s_data;
      for (int g = 0; g < GROUPS; g++) begin
        coef.scale[g] <= scale_mem[g][rd_ptr];
        coef.bias[g]  <= bias_mem[g][rd_ptr];
        coef.d[g]     <= d_reg[g];
      end
    end
  end

  // tables only change between bursts of data
  a_no_cfg_during_data: assert property (@(posedge clk) disable iff (reset)
    (clken && s_valid) |-> !(d_we || coef_we));

endmodule

//--- config/config_sequencer.sv
module config_sequencer (
  input  logic clk,
  input  logic reset,
  input  logic clken,
  input  logic config_valid,
  input  logic config_restart,
  output logic d_we,
  output logic coef_we,
  output logic [lrelu_pkg::ADDR_WIDTH-1:0] coef_waddr
);
  import lrelu_pkg::*;

  cfg_sel_e state;
  logic     beat;

  assign beat    = config_valid && !config_restart;  // restart swallows the beat
  assign d_we    = beat && (state == LOAD_D);
  assign coef_we = beat && (state == LOAD_COEF);

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= LOAD_D;
      coef_waddr <= '0;
    end else if (clken) begin
      if (config_restart) begin
        state      <= LOAD_D;
        coef_waddr <= '0;
      end else if (d_we) begin
        state      <= LOAD_COEF;  // entries follow the d word
        coef_waddr <= '0;
      end else if (coef_we) begin
        if (coef_waddr == ADDR_WIDTH'(KERNEL_DEPTH-1)) begin
          state      <= LOAD_D;  // table full, next beat is d again
          coef_waddr <= '0;
        end else begin
          coef_waddr <= coef_waddr + 1'b1;
        end
      end
    end
  end

  // entry counter only moves while the table is loading
  a_addr_idle: assert property (@(posedge clk) disable iff (reset)
    (state == LOAD_D) |-> (coef_waddr == '0));

endmodule

//--- datapath/affine_stage.sv
module affine_stage (
  input  logic clk,
  input  logic reset,
  input  logic clken,
  coef_if.sink coef,
  output logic p_valid,
  output logic p_lrelu,
  output logic [lrelu_pkg::GROUPS-1:0][lrelu_pkg::UNITS-1:0][lrelu_pkg::PROD_WIDTH-1:0] p_data,
  output logic [lrelu_pkg::GROUPS-1:0][lrelu_pkg::COEF_WIDTH-1:0] p_d
);
  import lrelu_pkg::*;

  logic signed [PROD_WIDTH-1:0] prod [GROUPS][UNITS];
  logic signed [PROD_WIDTH-1:0] sum  [GROUPS][UNITS];

  for (genvar g = 0; g < GROUPS; g++) begin : g_lane
    for (genvar u = 0; u < UNITS; u++) begin : u_lane
      // 32 x 16 fits 48 bits exactly
      assign prod[g][u] = PROD_WIDTH'($signed(coef.data[g][u]))
                        * PROD_WIDTH'($signed(coef.scale[g]));
      assign sum[g][u]  = (prod[g][u] >>> FRAC_SCALE)
                        + PROD_WIDTH'($signed(coef.bias[g]));
    end
  end

  always_ff @(posedge clk) begin
    if (reset)
      p_valid <= 1'b0;
    else if (clken)
      p_valid <= coef.valid;
  end

  always_ff @(posedge clk) begin
    if (clken) begin
      p_lrelu <= coef.lrelu;
      p_d     <= coef.d;  // d rides along for the offset stage
      for (int g = 0; g < GROUPS; g++)
        for (int u = 0; u < UNITS; u++)
          p_data[g][u] <= sum[g][u];
    end
  end

endmodule

//--- datapath/lrelu_requant.sv
module lrelu_requant (
  input  logic clk,
  input  logic reset,
  input  logic clken,
  input  logic p_valid,
  input  logic p_lrelu,
  input  logic [lrelu_pkg::GROUPS-1:0][lrelu_pkg::UNITS-1:0][lrelu_pkg::PROD_WIDTH-1:0] p_data,
  input  logic [lrelu_pkg::GROUPS-1:0][lrelu_pkg::COEF_WIDTH-1:0] p_d,
  output logic m_valid,
  output logic [lrelu_pkg::GROUPS-1:0][lrelu_pkg::UNITS-1:0][lrelu_pkg::WORD_WIDTH_OUT-1:0] m_data
);
  import lrelu_pkg::*;

  logic                          q_valid;
  logic [GROUPS-1:0][COEF_WIDTH-1:0] q_d;
  logic signed [PROD_WIDTH-1:0]  q_next [GROUPS][UNITS];
  logic signed [PROD_WIDTH-1:0]  q      [GROUPS][UNITS];
  logic signed [PROD_WIDTH-1:0]  r      [GROUPS][UNITS];
  logic [WORD_WIDTH_OUT-1:0]     sat    [GROUPS][UNITS];

  for (genvar g = 0; g < GROUPS; g++) begin : g_lane
    for (genvar u = 0; u < UNITS; u++) begin : u_lane
      // leaky slope only on negative values of flagged beats
      assign q_next[g][u] = (p_lrelu && $signed(p_data[g][u]) < 0)
                          ? ($signed(p_data[g][u]) * LRELU_ALPHA) >>> ALPHA_FRAC
                          : $signed(p_data[g][u]);

      assign r[g][u] = (q[g][u] + PROD_WIDTH'($signed(q_d[g]))) >>> OUT_SHIFT;

      always_comb begin
        if (r[g][u] > SAT_MAX)
          sat[g][u] = WORD_WIDTH_OUT'(SAT_MAX);
        else if (r[g][u] < SAT_MIN)
          sat[g][u] = WORD_WIDTH_OUT'(SAT_MIN);
        else
          sat[g][u] = r[g][u][WORD_WIDTH_OUT-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      q_valid <= 1'b0;
      m_valid <= 1'b0;
    end else if (clken) begin
      q_valid <= p_valid;
      m_valid <= q_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (clken) begin
      q_d <= p_d;
      for (int g = 0; g < GROUPS; g++) begin
        for (int u = 0; u < UNITS; u++) begin
          q[g][u]      <= q_next[g][u];
          m_data[g][u] <= sat[g][u];  // second stage, offset and clip
        end
      end
    end
  end

  // whole valid chain comes out of reset clean
  a_valid_known: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(m_valid));

endmodule

//--- rtl/lrelu_engine.sv
module lrelu_engine (
  input  logic clk,
  input  logic reset,
  input  logic clken,
  input  logic s_valid,
  input  logic s_lrelu,
  input  logic [lrelu_pkg::GROUPS*lrelu_pkg::UNITS*lrelu_pkg::WORD_WIDTH_IN-1:0]  s_data,
  output logic m_valid,
  output logic [lrelu_pkg::GROUPS*lrelu_pkg::UNITS*lrelu_pkg::WORD_WIDTH_OUT-1:0] m_data,
  input  logic config_valid,
  input  logic config_restart,
  input  logic [lrelu_pkg::GROUPS*lrelu_pkg::CFG_WIDTH-1:0] config_data
);
  import lrelu_pkg::*;

  logic d_we;
  logic coef_we;
  logic [ADDR_WIDTH-1:0] coef_waddr;

  logic p_valid;
  logic p_lrelu;
  logic [GROUPS-1:0][UNITS-1:0][PROD_WIDTH-1:0] p_data;
  logic [GROUPS-1:0][COEF_WIDTH-1:0] p_d;

  coef_if coef ();

  config_sequencer u_seq (
    .clk            (clk),
    .reset          (reset),
    .clken          (clken),
    .config_valid   (config_valid),
    .config_restart (config_restart),
    .d_we           (d_we),
    .coef_we        (coef_we),
    .coef_waddr     (coef_waddr)
  );

  // flat buses map straight onto the packed group/lane arrays
  coef_store u_store (
    .clk            (clk),
    .reset          (reset),
    .clken          (clken),
    .config_data    (config_data),
    .d_we           (d_we),
    .coef_we        (coef_we),
    .coef_waddr     (coef_waddr),
    .config_restart (config_restart),
    .s_valid        (s_valid),
    .s_lrelu        (s_lrelu),
    .s_data         (s_data),
    .coef           (coef.source)
  );

  affine_stage u_affine (
    .clk     (clk),
    .reset   (reset),
    .clken   (clken),
    .coef    (coef.sink),
    .p_valid (p_valid),
    .p_lrelu (p_lrelu),
    .p_data  (p_data),
    .p_d     (p_d)
  );

  lrelu_requant u_requant (
    .clk     (clk),
    .reset   (reset),
    .clken   (clken),
    .p_valid (p_valid),
    .p_lrelu (p_lrelu),
    .p_data  (p_data),
    .p_d     (p_d),
    .m_valid (m_valid),
    .m_data  (m_data)
  );

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the lrelu engine testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  -f sources.f --top-module tb_lrelu_engine -o tb_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- sources.f
common/lrelu_pkg.sv
common/coef_if.sv
config/config_sequencer.sv
config/coef_store.sv
datapath/affine_stage.sv
datapath/lrelu_requant.sv
rtl/lrelu_engine.sv
testbench/tb_lrelu_engine.sv

//--- testbench/tb_lrelu_engine.sv
module tb_lrelu_engine;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int GROUPS  = 2;
  localparam int UNITS   = 4;
  localparam int LANES   = GROUPS * UNITS;
  localparam int DEPTH   = 4;     // scale/bias entries per group
  localparam int LATENCY = 4;     // enabled cycles, input to output
  localparam int TIMEOUT = 3000;

  logic clk = 1'b0;
  logic reset;
  logic clken;
  logic s_valid;
  logic s_lrelu;
  logic [LANES*32-1:0] s_data;
  logic m_valid;
  logic [LANES*8-1:0] m_data;
  logic config_valid;
  logic config_restart;
  logic [GROUPS*32-1:0] config_data;

  int seed;
  int cycles = 0;
  longint en_cnt = 0;   // enabled edges seen so far
  int beat_n = 0;       // beats since reset or restart
  bit reset_seen = 1'b0;
  string test_name = "reset";

  // reference tables, sign extended
  longint d_m [GROUPS];
  longint scale_m [GROUPS][DEPTH];
  longint bias_m [GROUPS][DEPTH];

  logic [LANES*8-1:0] exp_data [$];
  longint exp_when [$];

  lrelu_engine u_dut (
    .clk            (clk),
    .reset          (reset),
    .clken          (clken),
    .s_valid        (s_valid),
    .s_lrelu        (s_lrelu),
    .s_data         (s_data),
    .m_valid        (m_valid),
    .m_data         (m_data),
    .config_valid   (config_valid),
    .config_restart (config_restart),
    .config_data    (config_data)
  );

  always #10 clk = ~clk;

  task automatic check(string name, logic [63:0] expected, logic [63:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %s expected %h actual %h", name, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic logic [7:0] lane_ref(logic [31:0] x, longint sc, longint bi,
                                          longint d, logic lrelu);
    longint p;
    longint r;
    p = $signed(x);
    p = ((p * sc) >>> 8) + bi;  // scale has 8 fraction bits
    if (lrelu && p < 0)
      p = (p * 26) >>> 8;       // slope of about 0.1
    r = (p + d) >>> 4;
    if (r > 127)
      r = 127;
    else if (r < -128)
      r = -128;
    return r[7:0];
  endfunction

  function automatic logic [LANES*8-1:0] model_beat(logic [LANES*32-1:0] data,
                                                     logic lrelu, int entry);
    logic [LANES*8-1:0] res;
    for (int g = 0; g < GROUPS; g++)
      for (int u = 0; u < UNITS; u++)
        res[(g*UNITS+u)*8 +: 8] = lane_ref(data[(g*UNITS+u)*32 +: 32], scale_m[g][entry],
                                           bias_m[g][entry], d_m[g], lrelu);
    return res;
  endfunction

  // small values mostly, full range now and then to hit saturation
  function automatic logic [31:0] gen_lane(int mode);
    int r;
    int sel;
    sel = $random(seed) & 7;
    r = $random(seed);
    if (sel == 0)
      return r;
    if (mode == 1 && sel < 6)
      return -(r & 32'hfff);  // negative bias for the slope
    return r % 1024;
  endfunction

  task automatic configure(bit restart);
    logic [GROUPS*32-1:0] word;
    logic signed [15:0] s;
    logic signed [15:0] b;
    logic signed [15:0] d;
    int junk;
    clken <= 1'b1;
    if (restart) begin
      // stray d beat leaves the sequencer mid-table
      config_valid <= 1'b1;
      config_data <= {$random(seed), $random(seed)};
      @(posedge clk);
      config_valid <= 1'b0;
      config_restart <= 1'b1;
      @(posedge clk);
      config_restart <= 1'b0;
    end
    for (int g = 0; g < GROUPS; g++) begin
      d = $random(seed) % 512;
      junk = $random(seed);
      d_m[g] = d;
      word[g*32 +: 32] = {junk[15:0], d};  // upper half is don't care
    end
    config_valid <= 1'b1;
    config_data <= word;
    @(posedge clk);
    for (int e = 0; e < DEPTH; e++) begin
      for (int g = 0; g < GROUPS; g++) begin
        s = $random(seed) % 1024;
        b = $random(seed) % 2048;
        scale_m[g][e] = s;
        bias_m[g][e] = b;
        word[g*32 +: 32] = {b, s};
      end
      config_data <= word;
      @(posedge clk);
    end
    config_valid <= 1'b0;
  endtask

  task automatic run_beats(int count, int mode, int stall_pct);
    int sent;
    bit en;
    bit flag;
    logic [LANES*32-1:0] data;
    sent = 0;
    while (sent < count) begin
      en = (stall_pct == 0) || (($unsigned($random(seed)) % 100) >= stall_pct);
      flag = (mode == 1) ? $random(seed) & 1 : 1'b0;
      for (int lane = 0; lane < LANES; lane++)
        data[lane*32 +: 32] = gen_lane(mode);
      clken <= en;
      s_valid <= 1'b1;
      s_lrelu <= flag;
      s_data <= data;
      @(posedge clk);
      if (en)
        sent++;
    end
    s_valid <= 1'b0;
    clken <= 1'b1;
  endtask

  task automatic drain();
    clken <= 1'b1;
    s_valid <= 1'b0;
    @(posedge clk);
    while (exp_data.size() != 0)
      @(posedge clk);
    repeat (2) @(posedge clk);
  endtask

  // model and checker, sampled before the edge updates
  always @(posedge clk) begin
    logic [LANES*8-1:0] exp_word;
    longint exp_time;
    if (reset) begin
      beat_n = 0;
      if (reset_seen)
        check("reset", 64'd0, {63'd0, m_valid});
      reset_seen = 1'b1;
    end else if (m_valid && exp_data.size() == 0) begin
      $display("%s: output beat appeared with nothing in flight", test_name);
      $display("TEST RESULT: FAIL");
      $fatal(1, "unexpected output");
    end else if (clken) begin
      if (m_valid) begin
        exp_word = exp_data.pop_front();
        exp_time = exp_when.pop_front();
        check({test_name, " latency"}, exp_time, en_cnt);
        check({test_name, " data"}, exp_word, m_data);
      end
      if (config_restart)
        beat_n = 0;
      if (s_valid) begin
        exp_data.push_back(model_beat(s_data, s_lrelu, beat_n % DEPTH));
        exp_when.push_back(en_cnt + LATENCY);
        beat_n++;
      end
      en_cnt++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("run timed out after %0d cycles in %s", cycles, test_name);
      $display("TEST RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  initial begin
    seed = 44946;
    reset = 1'b1;
    clken = 1'b1;
    s_valid = 1'b0;
    s_lrelu = 1'b0;
    s_data = '0;
    config_valid = 1'b0;
    config_restart = 1'b0;
    config_data = '0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    repeat (5) @(posedge clk);  // idle, m_valid must stay low
    configure(1'b0);
    test_name = "affine";
    run_beats(200, 0, 0);
    drain();
    test_name = "leaky";
    run_beats(200, 1, 0);
    drain();
    test_name = "stall";
    run_beats(201, 1, 30);  // odd count leaves the read pointer off entry 0
    drain();
    test_name = "reconfig";
    configure(1'b1);
    run_beats(100, 1, 0);
    drain();
    if (exp_data.size() == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("%0d beats never came out", exp_data.size());
      $display("TEST RESULT: FAIL");
      $fatal(1, "missing beats");
    end
  end

endmodule
